// File: verilog/coreDefs.sv
// Shared definitions for the femtoCore RV32I core
// Widths, opcode values, reset address and the instruction word formats
package coreDefs;
   localparam int xlen      = 32; // Data word width
   localparam int addrWidth = 24; // Internal address width
   localparam logic [addrWidth-1:0] resetAddr = '0; // First fetch address

   typedef logic [4:0] regIdT; // Register index

   // Opcode bits 6:2, bits 1:0 are always 11 in RV32I
   localparam logic [4:0] opLoad   = 5'b00000; // rd <- mem[rs1+Iimm]
   localparam logic [4:0] opAluImm = 5'b00100; // rd <- rs1 OP Iimm
   localparam logic [4:0] opAuipc  = 5'b00101; // rd <- PC + Uimm
   localparam logic [4:0] opStore  = 5'b01000; // mem[rs1+Simm] <- rs2
   localparam logic [4:0] opAluReg = 5'b01100; // rd <- rs1 OP rs2
   localparam logic [4:0] opLui    = 5'b01101; // rd <- Uimm
   localparam logic [4:0] opBranch = 5'b11000; // PC <- PC+Bimm if taken
   localparam logic [4:0] opJalr   = 5'b11001; // rd <- PC+4, PC <- rs1+Iimm
   localparam logic [4:0] opJal    = 5'b11011; // rd <- PC+4, PC <- PC+Jimm

   // One instruction word seen through each of its formats
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         regIdT rs2, rs1;
         logic [2:0] funct3;
         regIdT rd;
         logic [6:0] opcode;
      } rType;
      struct packed {
         logic [11:0] imm;
         regIdT rs1;
         logic [2:0] funct3;
         regIdT rd;
         logic [6:0] opcode;
      } iType;
      struct packed {
         logic [6:0] immHi;
         regIdT rs2, rs1;
         logic [2:0] funct3;
         logic [4:0] immLo;
         logic [6:0] opcode;
      } sType;
      struct packed {
         logic imm12;
         logic [5:0] imm10to5;
         regIdT rs2, rs1;
         logic [2:0] funct3;
         logic [3:0] imm4to1;
         logic imm11;
         logic [6:0] opcode;
      } bType;
      struct packed {
         logic [19:0] imm; // Upper 20 bits of the result
         regIdT rd;
         logic [6:0] opcode;
      } uType;
      struct packed {
         logic imm20;
         logic [9:0] imm10to1;
         logic imm11;
         logic [7:0] imm19to12;
         regIdT rd;
         logic [6:0] opcode;
      } jType;
   } instrT;
endpackage

// File: verilog/memPort.sv
// Memory requester port
// One requester on the shared bus, as seen by itself and by the arbiter
`timescale 1ns/10ps

interface memPort;
   logic [coreDefs::addrWidth-1:0] addr;  // Byte address
   logic [coreDefs::xlen-1:0]      wdata; // Lane-replicated store data
   logic [3:0]                     wmask; // Byte enables, write when nonzero
   logic                           rstrb; // One-cycle read request
   logic [coreDefs::xlen-1:0]      rdata;
   logic                           busy;  // High while the bus cannot serve us

   modport requester (
      output addr, wdata, wmask, rstrb,
      input  rdata, busy
   );

   modport arbiter (
      input  addr, wdata, wmask, rstrb,
      output rdata, busy
   );
endinterface

// File: verilog/issuePort.sv
// Issue port between fetch and execute
// Offers one fetched instruction and returns the next PC on retire
`timescale 1ns/10ps

interface issuePort;
   coreDefs::instrT                instr;  // Held until the next fetch
   logic [coreDefs::addrWidth-1:0] pc;     // Address of instr
   logic                           valid;  // Pulse, instr is new
   logic                           retire; // Pulse, instr is done
   logic [coreDefs::addrWidth-1:0] nextPc; // Fetch address after retire

   modport fetch (output instr, pc, valid, input retire, nextPc);
   modport exec  (input instr, pc, valid, output retire, nextPc);
endinterface

// File: verilog/aluCore.sv
// Integer ALU and branch predicate
// One 33-bit subtractor gives SUB, SLT, SLTU and all branch compares.
// One right shifter serves left shifts through bit reversal
`timescale 1ns/10ps

module aluCore (
   input  coreDefs::instrT           instr,
   input  logic [coreDefs::xlen-1:0] aluA,
   input  logic [coreDefs::xlen-1:0] aluB,
   output logic [coreDefs::xlen-1:0] aluResult,
   output logic                      branchTaken
);
   localparam int xl = coreDefs::xlen;

   logic [7:0] funct3Is;             // One-hot funct3
   logic [xl:0] aluMinus, shiftExt;
   logic [xl-1:0] aluPlus, shiftSrc, shiftOut, leftShift;
   logic lt, ltu, eq, isSub;

   assign funct3Is = 8'b0000_0001 << instr.rType.funct3;

   assign aluPlus  = aluA + aluB;
   assign aluMinus = {1'b1, ~aluB} + {1'b0, aluA} + 33'd1;
   assign ltu      = aluMinus[xl];   // Borrow out
   assign lt       = (aluA[xl-1] ^ aluB[xl-1]) ? aluA[xl-1] : ltu;
   assign eq       = aluMinus[xl-1:0] == '0;

   // Bit 30 set and register form, bit 30 of ADDI is an immediate bit
   assign isSub = instr.rType.funct7[5] & instr.rType.opcode[5];

   // Reverse in and out for SLL
   assign shiftSrc  = funct3Is[1] ? {<<{aluA}} : aluA;
   assign shiftExt  = $signed({instr.rType.funct7[5] & aluA[xl-1], shiftSrc}) >>> aluB[4:0];
   assign shiftOut  = shiftExt[xl-1:0];
   assign leftShift = {<<{shiftOut}};

   assign aluResult =
      (funct3Is[0] ? (isSub ? aluMinus[xl-1:0] : aluPlus) : '0) | // ADD, SUB
      (funct3Is[1] ? leftShift                           : '0) | // SLL
      (funct3Is[2] ? {{(xl-1){1'b0}}, lt}                : '0) | // SLT
      (funct3Is[3] ? {{(xl-1){1'b0}}, ltu}               : '0) | // SLTU
      (funct3Is[4] ? aluA ^ aluB                         : '0) | // XOR
      (funct3Is[5] ? shiftOut                            : '0) | // SRL, SRA
      (funct3Is[6] ? aluA | aluB                         : '0) | // OR
      (funct3Is[7] ? aluA & aluB                         : '0);  // AND

   assign branchTaken =
      (funct3Is[0] &  eq)  |  // BEQ
      (funct3Is[1] & ~eq)  |  // BNE
      (funct3Is[4] &  lt)  |  // BLT
      (funct3Is[5] & ~lt)  |  // BGE
      (funct3Is[6] &  ltu) |  // BLTU
      (funct3Is[7] & ~ltu);   // BGEU
endmodule

// File: verilog/fetchUnit.sv
// Instruction fetch unit
// Holds the PC and instruction register, reads one aligned word per
// instruction and offers it to the execute unit
`timescale 1ns/10ps

module fetchUnit (
   input logic       clk,
   input logic       reset,
   memPort.requester bus,
   issuePort.fetch   issue
);
   logic [coreDefs::addrWidth-1:0] pc;
   coreDefs::instrT instrReg;
   logic strobing, waiting, issued; // One-hot, all low right after reset
   logic valid;

   always_ff @(posedge clk) begin
      if (!reset) begin
         strobing <= 1'b0;
         waiting  <= 1'b0;
         issued   <= 1'b0;
         valid    <= 1'b0;
         pc       <= coreDefs::resetAddr;
      end else begin
         valid <= 1'b0;
         if (strobing) begin       // Read request goes out this cycle
            strobing <= 1'b0;
            waiting  <= 1'b1;
         end else if (waiting) begin
            if (!bus.busy) begin   // rdata holds the instruction
               waiting <= 1'b0;
               issued  <= 1'b1;
               valid   <= 1'b1;
            end
         end else if (issued) begin
            if (issue.retire) begin
               issued   <= 1'b0;
               strobing <= 1'b1;
               pc       <= issue.nextPc;
            end
         end else begin
            strobing <= 1'b1;      // First fetch after reset
         end
      end
   end

   // Instruction word, stable until the next fetch completes
   always_ff @(posedge clk) begin
      if (waiting && !bus.busy) instrReg <= bus.rdata;
   end

   assign bus.addr  = {pc[coreDefs::addrWidth-1:2], 2'b00}; // Word aligned
   assign bus.wdata = '0;   // Fetch never writes
   assign bus.wmask = 4'b0000;
   assign bus.rstrb = strobing;

   assign issue.instr = instrReg;
   assign issue.pc    = pc;
   assign issue.valid = valid;

   // Only one fetch in flight until the execute unit retires it
   assert property (@(posedge clk) disable iff (!reset)
      bus.rstrb |=> !bus.rstrb until issue.retire);
endmodule

// File: verilog/execUnit.sv
// Execute unit
// Register file, operand latch, execute sequencing, write-back
// and next-PC selection
`timescale 1ns/10ps

module execUnit (
   input  logic                      clk,
   input  logic                      reset,
   issuePort.exec                    issue,
   input  logic [coreDefs::xlen-1:0] aluResult,
   input  logic                      branchTaken,
   output logic [coreDefs::xlen-1:0] aluA,
   output logic [coreDefs::xlen-1:0] aluB,
   output logic                      start,
   output logic [coreDefs::xlen-1:0] storeData,
   output logic [coreDefs::xlen-1:0] baseAddr,
   input  logic [coreDefs::xlen-1:0] loadData,
   input  logic                      done
);
   localparam int aw = coreDefs::addrWidth;

   logic [coreDefs::xlen-1:0] regFile [32];
   logic [coreDefs::xlen-1:0] rs1Val, rs2Val;     // Latched operands
   logic [coreDefs::xlen-1:0] iImm, uImm, bImm, jImm;
   logic [coreDefs::xlen-1:0] pcPlusImm, jalrSum, wbData;
   logic [aw-1:0] pcPlus4;
   logic [4:0] op;
   coreDefs::regIdT rs1Idx, rs2Idx, rdIdx;
   logic isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui, isBranch, isJalr, isJal;
   logic isMem, executing, memWait, wbEn, regWrite;

   assign op     = issue.instr.rType.opcode[6:2];
   assign rs1Idx = issue.instr.rType.rs1;
   assign rs2Idx = issue.instr.rType.rs2;
   assign rdIdx  = issue.instr.rType.rd;

   assign isLoad   = op == coreDefs::opLoad;
   assign isAluImm = op == coreDefs::opAluImm;
   assign isAuipc  = op == coreDefs::opAuipc;
   assign isStore  = op == coreDefs::opStore;
   assign isAluReg = op == coreDefs::opAluReg;
   assign isLui    = op == coreDefs::opLui;
   assign isBranch = op == coreDefs::opBranch;
   assign isJalr   = op == coreDefs::opJalr;
   assign isJal    = op == coreDefs::opJal;
   assign isMem    = isLoad | isStore;

   assign iImm = {{20{issue.instr.iType.imm[11]}}, issue.instr.iType.imm};
   assign uImm = {issue.instr.uType.imm, 12'b0};
   assign bImm = {{20{issue.instr.bType.imm12}}, issue.instr.bType.imm11,
                  issue.instr.bType.imm10to5, issue.instr.bType.imm4to1, 1'b0};
   assign jImm = {{12{issue.instr.jType.imm20}}, issue.instr.jType.imm19to12,
                  issue.instr.jType.imm11, issue.instr.jType.imm10to1, 1'b0};

   // Operands read on valid, x0 forced to zero
   always_ff @(posedge clk) begin
      if (issue.valid) begin
         rs1Val <= (rs1Idx == '0) ? '0 : regFile[rs1Idx];
         rs2Val <= (rs2Idx == '0) ? '0 : regFile[rs2Idx];
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         executing <= 1'b0;
         memWait   <= 1'b0;
      end else begin
         executing <= issue.valid; // Execute cycle follows valid
         if (start) memWait <= 1'b1;
         else if (done) memWait <= 1'b0;
      end
   end

   assign start        = executing & isMem;
   assign issue.retire = (executing & ~isMem) | (memWait & done);

   assign aluA      = rs1Val;
   assign aluB      = (isAluReg | isBranch) ? rs2Val : iImm;
   assign storeData = rs2Val;
   assign baseAddr  = rs1Val;

   // PC-relative adder for AUIPC, JAL and branches
   assign pcPlusImm = {{(coreDefs::xlen - aw){1'b0}}, issue.pc}
                      + (isJal ? jImm : isAuipc ? uImm : bImm);
   assign jalrSum   = rs1Val + iImm;
   assign pcPlus4   = issue.pc + aw'(4);

   always_comb begin
      wbData = '0;
      if (isAluImm | isAluReg) wbData = aluResult;
      else if (isLui)          wbData = uImm;
      else if (isAuipc)        wbData = pcPlusImm;
      else if (isJal | isJalr) wbData = {{(coreDefs::xlen - aw){1'b0}}, pcPlus4};
      else if (isLoad)         wbData = loadData;
   end

   assign wbEn     = issue.retire & ~isBranch & ~isStore;
   assign regWrite = wbEn & (rdIdx != '0);

   always_ff @(posedge clk) begin
      if (regWrite) regFile[rdIdx] <= wbData;
   end

   assign issue.nextPc = isJalr ? {jalrSum[aw-1:1], 1'b0} :
                         (isJal | (isBranch & branchTaken)) ? pcPlusImm[aw-1:0] :
                         pcPlus4;

   // A load or store retires only with the unit's done
   assert property (@(posedge clk) disable iff (!reset)
      start |=> !issue.retire until done);
endmodule

// File: verilog/loadStoreUnit.sv
// Load/store unit
// Computes the data address, places store bytes on their lanes with the
// byte mask, and extracts and extends loaded bytes and halfwords
`timescale 1ns/10ps

module loadStoreUnit (
   input  logic                      clk,
   input  logic                      reset,
   input  coreDefs::instrT           instr,
   input  logic                      start,
   input  logic [coreDefs::xlen-1:0] baseAddr,
   input  logic [coreDefs::xlen-1:0] storeData,
   output logic [coreDefs::xlen-1:0] loadData,
   output logic                      done,
   memPort.requester                 bus
);
   localparam int aw = coreDefs::addrWidth;

   logic [coreDefs::xlen-1:0] sImm, iImm, offset, extracted;
   logic [aw-1:0] addr;
   logic [15:0] halfVal;
   logic [7:0] byteVal;
   logic [3:0] storeMask;
   logic isLoad, isStore, byteAcc, halfAcc, loadSign, pending;

   assign isLoad  = instr.iType.opcode[6:2] == coreDefs::opLoad;
   assign isStore = instr.sType.opcode[6:2] == coreDefs::opStore;
   assign byteAcc = instr.rType.funct3[1:0] == 2'b00;
   assign halfAcc = instr.rType.funct3[1:0] == 2'b01;

   assign sImm   = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
   assign iImm   = {{20{instr.iType.imm[11]}}, instr.iType.imm};
   assign offset = isStore ? sImm : iImm;
   assign addr   = baseAddr[aw-1:0] + offset[aw-1:0];

   // Byte and halfword copies on every lane
   assign bus.wdata = byteAcc ? {4{storeData[7:0]}} :
                      halfAcc ? {2{storeData[15:0]}} :
                      storeData;

   assign storeMask = byteAcc ? (4'b0001 << addr[1:0]) :
                      halfAcc ? (addr[1] ? 4'b1100 : 4'b0011) :
                      4'b1111;

   assign bus.addr  = addr;
   assign bus.wmask = (start & isStore) ? storeMask : 4'b0000;
   assign bus.rstrb = start & isLoad;

   // Field selection by address low bits
   assign halfVal   = addr[1] ? bus.rdata[31:16] : bus.rdata[15:0];
   assign byteVal   = addr[0] ? halfVal[15:8] : halfVal[7:0];
   assign loadSign  = ~instr.rType.funct3[2] & (byteAcc ? byteVal[7] : halfVal[15]);
   assign extracted = byteAcc ? {{24{loadSign}}, byteVal} :
                      halfAcc ? {{16{loadSign}}, halfVal} :
                      bus.rdata;

   always_ff @(posedge clk) begin
      if (!reset) begin
         pending <= 1'b0;
         done    <= 1'b0;
      end else begin
         done <= pending & ~bus.busy;         // Pulse after the access ends
         if (start) pending <= 1'b1;
         else if (!bus.busy) pending <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (pending && !bus.busy) loadData <= extracted;
   end

   // Execute waits for done before the next access
   assert property (@(posedge clk) disable iff (!reset) start |-> !pending);
endmodule

// File: verilog/busArbiter.sv
// Memory bus arbiter
// Puts the fetch unit or the load/store unit on the memory bus.
// Load/store requests win, and the owner holds while memory is busy
`timescale 1ns/10ps

module busArbiter (
   input  logic                           clk,
   input  logic                           reset,
   memPort.arbiter                        fetchBus,
   memPort.arbiter                        dataBus,
   output logic [coreDefs::addrWidth-1:0] memAddr,
   output logic [coreDefs::xlen-1:0]      memWdata,
   output logic [3:0]                     memWmask,
   output logic                           memRstrb,
   input  logic [coreDefs::xlen-1:0]      memRdata,
   input  logic                           memRbusy,
   input  logic                           memWbusy
);
   logic dataOwns;  // Registered owner, high for load/store
   logic dataSel;   // Owner in this cycle
   logic dataReq, fetchReq, memBusy;

   assign dataReq  = dataBus.rstrb | (dataBus.wmask != 4'b0000);
   assign fetchReq = fetchBus.rstrb;
   assign memBusy  = memRbusy | memWbusy;

   // A new request takes the bus in its own cycle
   always_comb begin
      dataSel = dataOwns;
      if (!memBusy) begin
         if (dataReq)       dataSel = 1'b1;
         else if (fetchReq) dataSel = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) dataOwns <= 1'b0;
      else dataOwns <= dataSel;
   end

   assign memAddr  = dataSel ? dataBus.addr  : fetchBus.addr;
   assign memWdata = dataSel ? dataBus.wdata : fetchBus.wdata;
   assign memWmask = dataSel ? dataBus.wmask : fetchBus.wmask;
   assign memRstrb = dataSel ? dataBus.rstrb : fetchBus.rstrb;

   assign fetchBus.rdata = memRdata;
   assign dataBus.rdata  = memRdata;
   assign fetchBus.busy  = memBusy | dataSel;  // Non-owner always waits
   assign dataBus.busy   = memBusy | ~dataSel;

   // Fetch and execute never overlap their requests
   assert property (@(posedge clk) disable iff (!reset) !(dataReq && fetchReq));
   // A request while memory is busy would be lost
   assert property (@(posedge clk) disable iff (!reset) memBusy |-> !dataReq && !fetchReq);
endmodule

// File: verilog/femtoCore.sv
// femtoCore top level
// Multi-cycle RV32I core with a single shared memory bus.
// Fetch and load/store requests reach memory through the bus arbiter
`timescale 1ns/10ps

module femtoCore (
   input  logic        clk,
   input  logic        reset,
   output logic [31:0] memAddr,
   output logic [31:0] memWdata,
   output logic [3:0]  memWmask,
   input  logic [31:0] memRdata,
   output logic        memRstrb,
   input  logic        memRbusy,
   input  logic        memWbusy
);
   logic [coreDefs::addrWidth-1:0] busAddr;
   logic [coreDefs::xlen-1:0] aluA, aluB, aluResult;
   logic [coreDefs::xlen-1:0] storeData, baseAddr, loadData;
   logic branchTaken, start, done;

   memPort   fetchBus ();
   memPort   dataBus ();
   issuePort issueIf ();

   fetchUnit fetchUnit_i (.clk(clk), .reset(reset), .bus(fetchBus), .issue(issueIf));

   execUnit execUnit_i (
      .clk(clk), .reset(reset), .issue(issueIf),
      .aluResult(aluResult), .branchTaken(branchTaken),
      .aluA(aluA), .aluB(aluB),
      .start(start), .storeData(storeData), .baseAddr(baseAddr),
      .loadData(loadData), .done(done)
   );

   aluCore aluCore_i (
      .instr(issueIf.instr), .aluA(aluA), .aluB(aluB),
      .aluResult(aluResult), .branchTaken(branchTaken)
   );

   loadStoreUnit loadStoreUnit_i (
      .clk(clk), .reset(reset), .instr(issueIf.instr), .start(start),
      .baseAddr(baseAddr), .storeData(storeData),
      .loadData(loadData), .done(done), .bus(dataBus)
   );

   busArbiter busArbiter_i (
      .clk(clk), .reset(reset), .fetchBus(fetchBus), .dataBus(dataBus),
      .memAddr(busAddr), .memWdata(memWdata), .memWmask(memWmask), .memRstrb(memRstrb),
      .memRdata(memRdata), .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   // Upper address bits are always zero
   assign memAddr = {{(coreDefs::xlen - coreDefs::addrWidth){1'b0}}, busAddr};
endmodule

// File: bench/testProgram.svh
// Test program for the femtoCore testbench
// Instruction encoders and the program builder with its expected results
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

localparam logic [6:0] opcImm = 7'b0010011, opcReg = 7'b0110011, opcLui = 7'b0110111;
localparam logic [6:0] opcAuipc = 7'b0010111, opcLoad = 7'b0000011;
localparam logic [6:0] opcStore = 7'b0100011, opcBranch = 7'b1100011;
localparam logic [6:0] opcJal = 7'b1101111, opcJalr = 7'b1100111;

// R-type table, A = -20 in x1 and B = 7 in x2
localparam logic [2:0] rF3 [10] = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
localparam logic [6:0] rF7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,
                                    7'h00, 7'h00, 7'h20};
localparam logic [31:0] rExp [10] = '{32'hFFFFFFF3, 32'hFFFFFFE5, 32'h1, 32'h0, 32'hFFFFFFEB,
                                      32'hFFFFFFEF, 32'h4, 32'hFFFFF600, 32'h01FFFFFF,
                                      32'hFFFFFFFF};

function automatic logic [31:0] rFormat(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, rs2);
   return {f7, rs2, rs1, f3, rd, opcReg};
endfunction

function automatic logic [31:0] iFormat(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, input int imm);
   return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic logic [31:0] sFormat(input logic [2:0] f3, input logic [4:0] rs2, rs1,
                                        input int imm);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], opcStore};
endfunction

function automatic logic [31:0] bFormat(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                        input int off);
   return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcBranch};
endfunction

function automatic logic [31:0] jFormat(input logic [4:0] rd, input int off);
   return {off[20], off[10:1], off[11], off[19:12], rd, opcJal};
endfunction

task automatic emit(input logic [31:0] word);
   image[pcW[10:2]] = word;
   pcW += 4;
endtask

task automatic emitTrap; // Word on a path that must never be fetched
   isTrap[pcW[10:2]] = 1'b1;
   emit(32'h0);
endtask

task automatic storeResult(input logic [4:0] rs, input logic [31:0] value);
   expVal[nSlots[5:0]] = value; // Slot n lives at 0x400 + 4n
   emit(sFormat(3'd2, rs, 5'd3, nSlots * 4));
   nSlots++;
endtask

task automatic immResult(input logic [2:0] f3, input logic [4:0] rs1, input int imm,
                         input logic [31:0] value);
   emit(iFormat(opcImm, f3, 5'd4, rs1, imm));
   storeResult(5'd4, value);
endtask

task automatic loadResult(input logic [2:0] f3, input int off, input logic [31:0] value);
   emit(iFormat(opcLoad, f3, 5'd4, 5'd15, off)); // Known word at 0x300
   storeResult(5'd4, value);
endtask

task automatic buildProgram;
   int here;
   emit(iFormat(opcImm, 3'd0, 5'd3, 5'd0, 32'h400)); // Result base
   emit(iFormat(opcImm, 3'd0, 5'd1, 5'd0, -20));
   emit(iFormat(opcImm, 3'd0, 5'd2, 5'd0, 7));
   for (int k = 0; k < 10; k++) begin
      emit(rFormat(rF7[k], rF3[k], 5'd4, 5'd1, 5'd2));
      storeResult(5'd4, rExp[k]);
   end
   immResult(3'd0, 5'd1, 100, 32'h50);             // ADDI
   immResult(3'd2, 5'd1, -19, 32'h1);              // SLTI
   immResult(3'd3, 5'd2, -1, 32'h1);               // SLTIU against all ones
   immResult(3'd4, 5'd1, 32'hFF, 32'hFFFFFF13);    // XORI
   immResult(3'd6, 5'd2, 32'h7F0, 32'h7F7);        // ORI
   immResult(3'd7, 5'd1, 32'h7F0, 32'h7E0);        // ANDI
   immResult(3'd1, 5'd2, 28, 32'h70000000);        // SLLI
   immResult(3'd5, 5'd1, 28, 32'hF);               // SRLI
   immResult(3'd5, 5'd1, 32'h402, 32'hFFFFFFFB);   // SRAI, funct7 bit in imm
   emit({20'hABCDE, 5'd4, opcLui});
   storeResult(5'd4, 32'hABCDE000);
   here = pcW;
   emit({20'h00001, 5'd4, opcAuipc});
   storeResult(5'd4, here + 32'h1000);
   emit({20'h12345, 5'd12, opcLui});
   emit(iFormat(opcImm, 3'd0, 5'd12, 5'd12, 32'h6A5)); // x12 = 0x123456A5
   emit({20'h00006, 5'd14, opcLui});
   emit(iFormat(opcImm, 3'd0, 5'd14, 5'd14, -32'h5C4)); // x14 = 0x5A3C
   emit(iFormat(opcImm, 3'd0, 5'd13, 5'd0, 32'h500));
   for (int k = 0; k < 4; k++) emit(sFormat(3'd0, 5'd12, 5'd13, k)); // SB each lane
   emit(sFormat(3'd1, 5'd14, 5'd13, 4));
   emit(sFormat(3'd1, 5'd14, 5'd13, 6));
   emit(iFormat(opcLoad, 3'd2, 5'd4, 5'd13, 0));
   storeResult(5'd4, 32'hA5A5A5A5);
   emit(iFormat(opcLoad, 3'd2, 5'd4, 5'd13, 4));
   storeResult(5'd4, 32'h5A3C5A3C);
   emit(iFormat(opcImm, 3'd0, 5'd15, 5'd0, 32'h300));
   loadResult(3'd0, 0, 32'hFFFFFF82);  // LB
   loadResult(3'd4, 0, 32'h00000082);  // LBU
   loadResult(3'd0, 3, 32'hFFFFFFC3);
   loadResult(3'd4, 2, 32'h0000007F);
   loadResult(3'd0, 1, 32'h00000001);
   loadResult(3'd1, 0, 32'h00000182);  // LH
   loadResult(3'd1, 2, 32'hFFFFC37F);
   loadResult(3'd5, 2, 32'h0000C37F);  // LHU
   loadResult(3'd2, 0, 32'hC37F0182);  // LW
   emit(iFormat(opcImm, 3'd0, 5'd5, 5'd0, 0));
   emit(iFormat(opcImm, 3'd0, 5'd6, 5'd0, 5));
   emit(iFormat(opcImm, 3'd0, 5'd5, 5'd5, 1));
   emit(bFormat(3'd1, 5'd5, 5'd6, -4));   // BNE loop, ends at 5
   emit(iFormat(opcImm, 3'd0, 5'd7, 5'd0, 0));
   emit(iFormat(opcImm, 3'd0, 5'd7, 5'd7, 2));
   emit(bFormat(3'd4, 5'd7, 5'd6, -4));   // BLT loop, ends at 6
   emit(iFormat(opcImm, 3'd0, 5'd8, 5'd0, 10));
   emit(iFormat(opcImm, 3'd0, 5'd8, 5'd8, -3));
   emit(bFormat(3'd7, 5'd8, 5'd6, -4));   // BGEU loop, ends at 4
   emit(bFormat(3'd0, 5'd0, 5'd0, 8));    // Always taken
   emitTrap();
   storeResult(5'd5, 32'd5);
   storeResult(5'd7, 32'd6);
   storeResult(5'd8, 32'd4);
   here = pcW;
   emit(jFormat(5'd9, 12));               // Call to the JALR below
   emit(jFormat(5'd10, 16));
   emitTrap();
   emit(iFormat(opcJalr, 3'd0, 5'd11, 5'd9, 0)); // Return to here+4
   emitTrap();
   storeResult(5'd9, here + 4);
   storeResult(5'd10, here + 8);
   storeResult(5'd11, here + 16);
   emit(iFormat(opcImm, 3'd0, 5'd16, 5'd0, sentinel));
   emit(sFormat(3'd2, 5'd16, 5'd0, 32'h7FC));
   emit(jFormat(5'd0, 0));                // Park
   progEnd = pcW;
endtask

`endif

// File: bench/femtoCoreTb.sv
// femtoCore testbench
// Memory model with random busy levels, program results checked by assertions
`timescale 1ns/10ps

module femtoCoreTb;
   localparam int timeoutCycles = 4000; // About 120 instructions at worst stall rate
   localparam int sentinel = 32'h5AD;
   // Byte enables at 0x500 to 0x507, SB to each byte then SH to each half
   localparam logic [3:0] laneMask [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                           4'b0011, 4'b0000, 4'b1100, 4'b0000};

   logic clk = 1'b0, reset = 1'b0;
   logic [31:0] memAddr, memWdata, memRdata = '0;
   logic [3:0] memWmask;
   logic memRstrb, memRbusy = 1'b0, memWbusy = 1'b0;

   logic [31:0] image [512];  // Initial memory contents
   logic [31:0] mem [512];
   logic [31:0] expVal [64];
   logic isTrap [512];
   int pcW = 0, nSlots = 0, progEnd = 0, slotsSeen = 0, cycleCount = 0;
   int unsigned rCount = 0, wCount = 0, seedInit;

   `include "testProgram.svh"

   femtoCore femtoCore_i (.*);

   always #2 clk = ~clk;

   initial begin
      seedInit = $urandom(32'hd5bc);
      for (int i = 0; i < 512; i++) begin
         image[i] = 32'hDEAD0000 ^ (i * 32'h00010001); // Address-dependent fill
         isTrap[i] = 1'b0;
      end
      image[192] = 32'hC37F0182; // Known word at 0x300
      buildProgram();
      repeat (10) @(posedge clk);
      reset <= 1'b1;
   end

   task automatic failRun;
      $display("Verification failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic valueError(input string name, input logic [31:0] exp, act);
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      failRun();
   endtask

   task automatic protocolError(input string what);
      $display("Error at %0t: %s", $time, what);
      failRun();
   endtask

   // Memory model, reads answer one cycle after rstrb unless stalled
   always @(posedge clk) begin
      int unsigned stall;
      stall = ($urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
      if (!reset) begin
         mem <= image;
         memRbusy <= 1'b0;
         memWbusy <= 1'b0;
         rCount <= 0;
         wCount <= 0;
      end else begin
         if (memRstrb) begin
            memRdata <= mem[memAddr[10:2]];
            memRbusy <= stall != 0;
            rCount <= stall;
         end else if (rCount != 0) begin
            rCount <= rCount - 1;
            memRbusy <= rCount > 1;
         end
         if (memWmask != 4'b0000) begin
            for (int b = 0; b < 4; b++)
               if (memWmask[b]) mem[memAddr[10:2]][8*b +: 8] <= memWdata[8*b +: 8];
            memWbusy <= stall != 0;
            wCount <= stall;
         end else if (wCount != 0) begin
            wCount <= wCount - 1;
            memWbusy <= wCount > 1;
         end
      end
   end

   // Result words
   assert property (@(posedge clk) disable iff (!reset)
      (memWmask == 4'hF && memAddr[31:8] == 24'h4) |-> memWdata == expVal[memAddr[7:2]])
      else valueError("memWdata", expVal[$sampled(memAddr) >> 2 & 32'h3F], $sampled(memWdata));
   // Byte lanes at 0x500, halfword lanes at 0x504
   assert property (@(posedge clk) disable iff (!reset)
      (memWmask != 0 && memAddr[31:3] == 29'hA0) |-> memWmask == laneMask[memAddr[2:0]])
      else valueError("memWmask", 32'(laneMask[$sampled(memAddr[2:0])]),
                      32'($sampled(memWmask)));
   assert property (@(posedge clk) disable iff (!reset)
      (memWmask != 0 && memAddr[31:2] == 30'h140) |-> memWdata == 32'hA5A5A5A5)
      else valueError("memWdata", 32'hA5A5A5A5, $sampled(memWdata));
   assert property (@(posedge clk) disable iff (!reset)
      (memWmask != 0 && memAddr[31:2] == 30'h141) |-> memWdata == 32'h5A3C5A3C)
      else valueError("memWdata", 32'h5A3C5A3C, $sampled(memWdata));
   // Fetches stay on the program path
   assert property (@(posedge clk) disable iff (!reset)
      (memRstrb && memAddr < 32'h300) |-> (memAddr < progEnd && !isTrap[memAddr[10:2]]))
      else protocolError("instruction fetched from outside the program path");
   // Back-pressure
   assert property (@(posedge clk) disable iff (!reset)
      (memRbusy || memWbusy) |-> $stable(memAddr) && $stable(memWdata))
      else protocolError("memAddr or memWdata changed while memory was busy");
   assert property (@(posedge clk) disable iff (!reset)
      (memRbusy || memWbusy) |-> !memRstrb && memWmask == 4'b0000)
      else protocolError("new memory request issued while memory was busy");
   assert property (@(posedge clk) disable iff (!reset) !(memRstrb && memWmask != 4'b0000))
      else protocolError("memRstrb and memWmask active in the same cycle");

   // Sentinel store ends the run, timeout guards against a hang
   always @(posedge clk) begin
      if (reset) begin
         cycleCount <= cycleCount + 1;
         if (memWmask == 4'hF && memAddr[31:8] == 24'h4) slotsSeen <= slotsSeen + 1;
         if (memWmask != 4'b0000 && memAddr == 32'h7FC) begin
            if (memWdata == sentinel && slotsSeen == nSlots) begin
               $display("Verification passed");
               $finish;
            end else begin
               $display("Sentinel store with %0d of %0d results seen", slotsSeen, nSlots);
               failRun();
            end
         end else if (cycleCount == timeoutCycles) begin
            $display("Timeout after %0d cycles without the sentinel store", cycleCount);
            failRun();
         end
      end
   end
endmodule

// File: femtoCore.f
+incdir+bench
verilog/coreDefs.sv
verilog/memPort.sv
verilog/issuePort.sv
verilog/aluCore.sv
verilog/fetchUnit.sv
verilog/execUnit.sv
verilog/loadStoreUnit.sv
verilog/busArbiter.sv
verilog/femtoCore.sv
bench/femtoCoreTb.sv

// File: run.sh
#!/bin/bash
# Build and run the femtoCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f femtoCore.f --top-module femtoCoreTb -o femtoCoreSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/femtoCoreSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "Verification passed"; then
   exit 0
fi
exit 1
